/* design/sram_pkg.sv */
package sram_pkg;

  // AXI-lite side
  localparam int axil_addr_width = 12;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // SRAM side
  localparam int word_addr_width = 10;
  localparam int bank_count = 4;
  localparam int bank_sel_width = 2;
  localparam int row_width = 8;

  localparam logic [1:0] resp_okay = 2'b00;

  // word address seen either flat or as row and bank
  // bank in the low bits so consecutive words land in different banks
  typedef union packed {
    logic [word_addr_width-1:0] flat;
    struct packed {
      logic [row_width-1:0] row;
      logic [bank_sel_width-1:0] bank;
    } split;
  } sram_addr_u;

endpackage

/* design/axil_sram_bridge.sv */
`timescale 1ns/1ps

module axil_sram_bridge (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic [sram_pkg::axil_addr_width-1:0] awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [sram_pkg::data_width-1:0]      wdata,
  input  logic [sram_pkg::strb_width-1:0]      wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic                                 bvalid,
  output logic [1:0]                           bresp,
  input  logic                                 bready,

  input  logic [sram_pkg::axil_addr_width-1:0] araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [sram_pkg::data_width-1:0]      rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,

  output logic                                 cmd_valid,
  input  logic                                 cmd_ready,
  output logic [sram_pkg::word_addr_width-1:0] cmd_addr,
  output logic                                 cmd_wr_en,
  output logic [sram_pkg::data_width-1:0]      cmd_wr_data,
  output logic [sram_pkg::strb_width-1:0]      cmd_wr_strb,

  input  logic                                 rd_resp_valid,
  input  logic [sram_pkg::data_width-1:0]      rd_resp_data,
  output logic                                 rd_resp_ready
);
  import sram_pkg::*;

  logic                       aw_held;
  logic [axil_addr_width-1:0] aw_addr_q;
  logic                       w_held;
  logic [data_width-1:0]      w_data_q;
  logic [strb_width-1:0]      w_strb_q;
  logic                       b_pending;

  logic                       aw_present;
  logic                       w_present;
  logic [axil_addr_width-1:0] wr_addr;
  logic                       b_block;
  logic                       wr_go;
  logic                       wr_acc;

  // held halves win over the live channel
  assign aw_present = aw_held | awvalid;
  assign w_present  = w_held | wvalid;
  assign wr_addr    = aw_held ? aw_addr_q : awaddr;

  // only one write response outstanding
  assign b_block = b_pending & ~bready;
  assign wr_go   = aw_present & w_present & ~b_block;
  assign wr_acc  = wr_go & cmd_ready;

  // writes take the command port first
  assign cmd_valid   = wr_go | arvalid;
  assign cmd_wr_en   = wr_go;
  assign cmd_addr    = wr_go ? wr_addr[axil_addr_width-1:2] : araddr[axil_addr_width-1:2];
  assign cmd_wr_data = w_held ? w_data_q : wdata;
  assign cmd_wr_strb = w_held ? w_strb_q : wstrb;

  // a free skid slot always takes its half
  assign awready = ~aw_held;
  assign wready  = ~w_held;
  assign arready = ~wr_go & cmd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_held <= 1'b0;
    end else if (wr_acc) begin
      aw_held <= 1'b0;
    end else if (awvalid && !aw_held) begin
      aw_held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && !aw_held && !wr_acc) begin
      aw_addr_q <= awaddr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_held <= 1'b0;
    end else if (wr_acc) begin
      w_held <= 1'b0;
    end else if (wvalid && !w_held) begin
      w_held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wvalid && !w_held && !wr_acc) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
  end

  // b response on the edge after the write is accepted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_pending <= 1'b0;
    end else if (wr_acc) begin
      b_pending <= 1'b1;
    end else if (bready) begin
      b_pending <= 1'b0;
    end
  end

  assign bvalid = b_pending;
  assign bresp  = resp_okay;

  // read data comes straight from the merge
  assign rvalid        = rd_resp_valid;
  assign rdata         = rd_resp_data;
  assign rresp         = resp_okay;
  assign rd_resp_ready = rready;

endmodule

/* design/bank_dispatch.sv */
`timescale 1ns/1ps

module bank_dispatch (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic                                 cmd_valid,
  output logic                                 cmd_ready,
  input  logic [sram_pkg::word_addr_width-1:0] cmd_addr,
  input  logic                                 cmd_wr_en,
  input  logic [sram_pkg::data_width-1:0]      cmd_wr_data,
  input  logic [sram_pkg::strb_width-1:0]      cmd_wr_strb,

  output logic [sram_pkg::bank_count-1:0]      bank_cmd_valid,
  input  logic [sram_pkg::bank_count-1:0]      bank_cmd_ready,
  output logic [sram_pkg::row_width-1:0]       bank_row,
  output logic                                 bank_wr_en,
  output logic [sram_pkg::data_width-1:0]      bank_wr_data,
  output logic [sram_pkg::strb_width-1:0]      bank_wr_strb,

  output logic                                 ord_push,
  output logic [sram_pkg::bank_sel_width-1:0]  ord_bank,
  input  logic                                 ord_full
);
  import sram_pkg::*;

  sram_addr_u addr;
  logic       ord_ok;
  logic       rd_acc;

  assign addr.flat = cmd_addr;

  // reads also need room in the order FIFO
  assign ord_ok = cmd_wr_en | ~ord_full;

  always_comb begin
    bank_cmd_valid = '0;
    bank_cmd_valid[addr.split.bank] = cmd_valid & ord_ok;
  end

  assign cmd_ready = bank_cmd_ready[addr.split.bank] & ord_ok;
  assign rd_acc    = cmd_valid & cmd_ready & ~cmd_wr_en;

  // row and write payload are shared by all banks
  assign bank_row     = addr.split.row;
  assign bank_wr_en   = cmd_wr_en;
  assign bank_wr_data = cmd_wr_data;
  assign bank_wr_strb = cmd_wr_strb;

  // order entry appears together with the bank's response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ord_push <= 1'b0;
    end else begin
      ord_push <= rd_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      ord_bank <= addr.split.bank;
    end
  end

endmodule

/* design/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank (
  input  logic                            clk,
  input  logic                            rst_n,

  input  logic                            cmd_valid,
  output logic                            cmd_ready,
  input  logic [sram_pkg::row_width-1:0]  row,
  input  logic                            wr_en,
  input  logic [sram_pkg::data_width-1:0] wr_data,
  input  logic [sram_pkg::strb_width-1:0] wr_strb,

  output logic                            resp_valid,
  output logic [sram_pkg::data_width-1:0] resp_data,
  input  logic                            resp_ready
);
  import sram_pkg::*;

  logic [data_width-1:0] mem [2**row_width];
  logic                  cmd_acc;

  // busy while the response register holds undrained data
  assign cmd_ready = ~resp_valid | resp_ready;
  assign cmd_acc   = cmd_valid & cmd_ready;

  always_ff @(posedge clk) begin
    if (cmd_acc && wr_en) begin
      for (int b = 0; b < strb_width; b++) begin
        if (wr_strb[b]) begin
          mem[row][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_acc && !wr_en) begin
      resp_data <= mem[row];
    end
  end

  // writes never raise a response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (cmd_acc && !wr_en) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

endmodule

/* design/bank_resp_merge.sv */
`timescale 1ns/1ps

module bank_resp_merge (
  input  logic                                                     clk,
  input  logic                                                     rst_n,

  input  logic                                                     ord_push,
  input  logic [sram_pkg::bank_sel_width-1:0]                      ord_bank,
  output logic                                                     ord_full,

  input  logic [sram_pkg::bank_count-1:0]                          bank_resp_valid,
  input  logic [sram_pkg::bank_count-1:0][sram_pkg::data_width-1:0] bank_resp_data,
  output logic [sram_pkg::bank_count-1:0]                          bank_resp_ready,

  output logic                                                     rd_resp_valid,
  output logic [sram_pkg::data_width-1:0]                          rd_resp_data,
  input  logic                                                     rd_resp_ready
);
  import sram_pkg::*;

  // a bank holds one read at most so one entry per bank
  logic [bank_sel_width-1:0] ord_q [bank_count];
  logic [bank_sel_width-1:0] wr_ptr;
  logic [bank_sel_width-1:0] rd_ptr;
  logic [bank_sel_width:0]   count;

  logic                      fifo_empty;
  logic                      head_valid;
  logic [bank_sel_width-1:0] head_bank;
  logic                      take;
  logic                      push_store;
  logic                      pop;

  assign fifo_empty = (count == '0);

  // count the push still on its way in
  assign ord_full = (int'(count) + int'(ord_push)) >= bank_count;

  // incoming entry is the head of an empty FIFO
  assign head_bank  = fifo_empty ? ord_bank : ord_q[rd_ptr];
  assign head_valid = ~fifo_empty | ord_push;

  assign rd_resp_valid = head_valid & bank_resp_valid[head_bank];
  assign rd_resp_data  = bank_resp_data[head_bank];

  always_comb begin
    bank_resp_ready = '0;
    bank_resp_ready[head_bank] = head_valid & rd_resp_ready;
  end

  assign take       = rd_resp_valid & rd_resp_ready;
  assign push_store = ord_push & ~(fifo_empty & take);
  assign pop        = take & ~fifo_empty;

  always_ff @(posedge clk) begin
    if (push_store) begin
      ord_q[wr_ptr] <= ord_bank;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_store) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_store && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push_store) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* design/axil_sram_top.sv */
`timescale 1ns/1ps

module axil_sram_top (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic [sram_pkg::axil_addr_width-1:0] awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [sram_pkg::data_width-1:0]      wdata,
  input  logic [sram_pkg::strb_width-1:0]      wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic                                 bvalid,
  output logic [1:0]                           bresp,
  input  logic                                 bready,

  input  logic [sram_pkg::axil_addr_width-1:0] araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [sram_pkg::data_width-1:0]      rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready
);
  import sram_pkg::*;

  logic                       cmd_valid;
  logic                       cmd_ready;
  logic [word_addr_width-1:0] cmd_addr;
  logic                       cmd_wr_en;
  logic [data_width-1:0]      cmd_wr_data;
  logic [strb_width-1:0]      cmd_wr_strb;

  logic [bank_count-1:0]      bank_cmd_valid;
  logic [bank_count-1:0]      bank_cmd_ready;
  logic [row_width-1:0]       bank_row;
  logic                       bank_wr_en;
  logic [data_width-1:0]      bank_wr_data;
  logic [strb_width-1:0]      bank_wr_strb;

  logic [bank_count-1:0]                 bank_resp_valid;
  logic [bank_count-1:0][data_width-1:0] bank_resp_data;
  logic [bank_count-1:0]                 bank_resp_ready;

  logic                       ord_push;
  logic [bank_sel_width-1:0]  ord_bank;
  logic                       ord_full;

  logic                       rd_resp_valid;
  logic [data_width-1:0]      rd_resp_data;
  logic                       rd_resp_ready;

  axil_sram_bridge bridge_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bvalid        (bvalid),
    .bresp         (bresp),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_addr      (cmd_addr),
    .cmd_wr_en     (cmd_wr_en),
    .cmd_wr_data   (cmd_wr_data),
    .cmd_wr_strb   (cmd_wr_strb),
    .rd_resp_valid (rd_resp_valid),
    .rd_resp_data  (rd_resp_data),
    .rd_resp_ready (rd_resp_ready)
  );

  bank_dispatch dispatch_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_addr       (cmd_addr),
    .cmd_wr_en      (cmd_wr_en),
    .cmd_wr_data    (cmd_wr_data),
    .cmd_wr_strb    (cmd_wr_strb),
    .bank_cmd_valid (bank_cmd_valid),
    .bank_cmd_ready (bank_cmd_ready),
    .bank_row       (bank_row),
    .bank_wr_en     (bank_wr_en),
    .bank_wr_data   (bank_wr_data),
    .bank_wr_strb   (bank_wr_strb),
    .ord_push       (ord_push),
    .ord_bank       (ord_bank),
    .ord_full       (ord_full)
  );

  for (genvar i = 0; i < bank_count; i++) begin : g_bank
    sram_bank bank_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (bank_cmd_valid[i]),
      .cmd_ready  (bank_cmd_ready[i]),
      .row        (bank_row),
      .wr_en      (bank_wr_en),
      .wr_data    (bank_wr_data),
      .wr_strb    (bank_wr_strb),
      .resp_valid (bank_resp_valid[i]),
      .resp_data  (bank_resp_data[i]),
      .resp_ready (bank_resp_ready[i])
    );
  end

  bank_resp_merge merge_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .ord_push        (ord_push),
    .ord_bank        (ord_bank),
    .ord_full        (ord_full),
    .bank_resp_valid (bank_resp_valid),
    .bank_resp_data  (bank_resp_data),
    .bank_resp_ready (bank_resp_ready),
    .rd_resp_valid   (rd_resp_valid),
    .rd_resp_data    (rd_resp_data),
    .rd_resp_ready   (rd_resp_ready)
  );

endmodule

/* tests/axil_sram_checker.sv */
`timescale 1ns/1ps

module axil_sram_checker (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            awvalid,
  input  logic                            awready,
  input  logic                            wvalid,
  input  logic                            wready,
  input  logic                            bvalid,
  input  logic [1:0]                      bresp,
  input  logic                            bready,
  input  logic                            arvalid,
  input  logic                            arready,
  input  logic [sram_pkg::data_width-1:0] rdata,
  input  logic [1:0]                      rresp,
  input  logic                            rvalid,
  input  logic                            rready,
  input  logic [sram_pkg::data_width-1:0] exp_rdata,
  input  logic                            summary_req,
  output int                              mismatch_count,
  output int                              protocol_count,
  output int                              reads_pending
);
  import sram_pkg::*;

  logic [data_width-1:0] exp_q [$];
  logic [data_width-1:0] expected;
  logic [data_width-1:0] stall_data;
  logic                  stalled;
  logic                  out_of_reset;
  int                    aw_count;
  int                    w_count;
  int                    b_count;

  always @(posedge clk) begin
    if (!rst_n) begin
      out_of_reset = 1'b0;
      stalled = 1'b0;
      exp_q.delete();
      aw_count = 0;
      w_count = 0;
      b_count = 0;
    end else begin
      if (!out_of_reset && (bvalid || rvalid)) begin
        $display("%0t: bvalid or rvalid is high right after reset", $time);
        protocol_count++;
      end
      out_of_reset = 1'b1;

      // a b response needs both halves of a write that has no response yet
      if (bvalid && (aw_count <= b_count || w_count <= b_count)) begin
        $display("%0t: write response with no outstanding write", $time);
        protocol_count++;
      end
      if (bvalid && bready) begin
        b_count++;
        if (bresp != resp_okay) begin
          $display("MISMATCH %0t: bresp %b, expected OKAY", $time, bresp);
          mismatch_count++;
        end
      end
      if (awvalid && awready) begin
        aw_count++;
      end
      if (wvalid && wready) begin
        w_count++;
      end

      // stalled read data must not move
      if (stalled && (!rvalid || rdata !== stall_data)) begin
        $display("MISMATCH %0t: read data %h changed while stalled, was %h",
                 $time, rdata, stall_data);
        mismatch_count++;
      end
      if (rvalid && rready) begin
        if (exp_q.size() == 0) begin
          $display("%0t: read data returned with no outstanding read", $time);
          protocol_count++;
        end else begin
          expected = exp_q.pop_front();
          if (rdata !== expected) begin
            $display("MISMATCH %0t: read data %h, expected %h", $time, rdata, expected);
            mismatch_count++;
          end
        end
        if (rresp != resp_okay) begin
          $display("MISMATCH %0t: rresp %b, expected OKAY", $time, rresp);
          mismatch_count++;
        end
      end
      stalled = rvalid && !rready;
      stall_data = rdata;

      if (arvalid && arready) begin
        exp_q.push_back(exp_rdata);
      end
    end
    reads_pending = exp_q.size();
  end

  always @(posedge summary_req) begin
    $display("checker: %0d value mismatches, %0d protocol errors, %0d reads outstanding",
             mismatch_count, protocol_count, reads_pending);
  end

endmodule

/* tests/axil_sram_tb.sv */
`timescale 1ns/1ps

module axil_sram_tb;
  import sram_pkg::*;

  localparam int fill_words = 2**word_addr_width;
  localparam int strobe_ops = 64;
  localparam int burst_len = 16;
  localparam int burst_count = 8;
  localparam int mix_ops = 256;
  localparam int op_count = 4 + 2*fill_words + 2*strobe_ops + burst_len*burst_count + mix_ops;
  localparam int timeout_cycles = 20 * op_count;

  logic                       clk;
  logic                       rst_n;
  logic [axil_addr_width-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [data_width-1:0]      wdata;
  logic [strb_width-1:0]      wstrb;
  logic                       wvalid;
  logic                       wready;
  logic                       bvalid;
  logic [1:0]                 bresp;
  logic                       bready;
  logic [axil_addr_width-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [data_width-1:0]      rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready = 1'b1;

  logic [data_width-1:0]      shadow [fill_words];
  logic [data_width-1:0]      exp_rdata;
  logic                       summary_req;
  logic                       random_rready;
  int                         seed = 8;
  int                         cycle_count;
  int                         mismatch_count;
  int                         protocol_count;
  int                         reads_pending;

  axil_sram_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  axil_sram_checker chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .awvalid        (awvalid),
    .awready        (awready),
    .wvalid         (wvalid),
    .wready         (wready),
    .bvalid         (bvalid),
    .bresp          (bresp),
    .bready         (bready),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .exp_rdata      (exp_rdata),
    .summary_req    (summary_req),
    .mismatch_count (mismatch_count),
    .protocol_count (protocol_count),
    .reads_pending  (reads_pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    int r;
    r = $random(seed);
    if (random_rready) begin
      rready = r[0] | r[1];
    end else begin
      rready = 1'b1;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

  function automatic logic [data_width-1:0] expected_word(
    input logic [word_addr_width-1:0] word
  );
    return shadow[word];
  endfunction

  // old bytes stay where the strobe is low
  function automatic logic [data_width-1:0] merge_bytes(
    input logic [data_width-1:0] old_word,
    input logic [data_width-1:0] new_word,
    input logic [strb_width-1:0] strb
  );
    logic [data_width-1:0] result;
    result = old_word;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // tasks start and end on a falling edge and sample outputs 5 ns after it
  task automatic send_aw(input logic [word_addr_width-1:0] word);
    awaddr = {word, 2'b00};
    awvalid = 1'b1;
    #5;
    while (!awready) begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
    awvalid = 1'b0;
  endtask

  task automatic send_w(input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
    wdata = data;
    wstrb = strb;
    wvalid = 1'b1;
    #5;
    while (!wready) begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
    wvalid = 1'b0;
  endtask

  task automatic wait_bresp();
    #5;
    while (!bvalid) begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
  endtask

  // mode 1 sends aw first, mode 2 sends w first, else both together
  task automatic write_word(
    input logic [word_addr_width-1:0] word,
    input logic [data_width-1:0]      data,
    input logic [strb_width-1:0]      strb,
    input int                         mode,
    input int                         gap
  );
    shadow[word] = merge_bytes(shadow[word], data, strb);
    case (mode)
      1: begin
        send_aw(word);
        repeat (gap) @(negedge clk);
        send_w(data, strb);
      end
      2: begin
        send_w(data, strb);
        repeat (gap) @(negedge clk);
        send_aw(word);
      end
      default: begin
        fork
          send_aw(word);
          send_w(data, strb);
        join
      end
    endcase
    wait_bresp();
  endtask

  task automatic read_word(input logic [word_addr_width-1:0] word);
    araddr = {word, 2'b00};
    arvalid = 1'b1;
    exp_rdata = expected_word(word);
    #5;
    while (!arready) begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic drain_reads();
    #5;
    while (reads_pending != 0) begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
  endtask

  task automatic read_burst(input logic [word_addr_width-1:0] base);
    for (int k = 0; k < burst_len; k++) begin
      read_word(base + word_addr_width'(k));
    end
    drain_reads();
  endtask

  initial begin
    logic [word_addr_width-1:0] word;
    logic [data_width-1:0]      data;
    int                         r;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    exp_rdata = '0;
    summary_req = 1'b0;
    random_rready = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // a lone aw and a lone w are held without a response
    write_word(10'd0, 32'h5a5a_0001, 4'hf, 1, 6);
    read_word(10'd0);
    write_word(10'd1, 32'ha5a5_0002, 4'hf, 2, 6);
    read_word(10'd1);

    // fill every word while cycling through the aw/w arrival orders
    for (int i = 0; i < fill_words; i++) begin
      word = word_addr_width'(i);
      data = $random(seed);
      write_word(word, data, 4'hf, i % 3, 2);
      read_word(word);
    end
    drain_reads();

    for (int i = 0; i < strobe_ops; i++) begin
      r = $random(seed);
      word = r[word_addr_width-1:0];
      data = $random(seed);
      write_word(word, data, r[15:12], r[17:16], 1);
      read_word(word);
    end
    drain_reads();

    // bursts with rready high and then with random back-pressure
    for (int b = 0; b < burst_count; b++) begin
      random_rready = (b >= burst_count / 2);
      r = $random(seed);
      read_burst(r[word_addr_width-1:0]);
    end

    random_rready = 1'b1;
    for (int i = 0; i < mix_ops; i++) begin
      r = $random(seed);
      word = r[word_addr_width+3:4];
      if (r[0]) begin
        data = $random(seed);
        write_word(word, data, r[23:20], r[2:1], 1);
      end else begin
        read_word(word);
      end
    end
    random_rready = 1'b0;
    drain_reads();

    summary_req = 1'b1;
    #1;
    if (mismatch_count + protocol_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
design/sram_pkg.sv
design/axil_sram_bridge.sv
design/bank_dispatch.sv
design/sram_bank.sv
design/bank_resp_merge.sv
design/axil_sram_top.sv
tests/axil_sram_checker.sv
tests/axil_sram_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module axil_sram_tb -f sim.f \
  -o axil_sram_sim > build.log 2>&1 &&
./obj_dir/axil_sram_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "Test passed" sim.log && echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }
